// ==== design/tile_params.svh ====
/*
 * Size macros for the backend slice
 *   group width, data widths, register file geometry
 *   writeback and read port counts
 *   credit pool sizes and the credit counter width
 */
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// ----------------------------------------------------------------------
// Dispatch group and data widths
// ----------------------------------------------------------------------
`define TILE_DISP_SIZE    4
`define TILE_XLEN         64
`define TILE_FLEN         32
`define TILE_PHY_REGS     32
`define TILE_RNID_W       5
`define TILE_WB_PORTS     4
`define TILE_INT_RD_PORTS 2
`define TILE_FP_RD_PORTS  2

// ----------------------------------------------------------------------
// Credit pools
// ----------------------------------------------------------------------
`define TILE_ROB_SIZE     16
`define TILE_ALU_SIZE     8
`define TILE_LSU_SIZE     8
`define TILE_BRU_SIZE     4
`define TILE_FPU_SIZE     4
`define TILE_CNT_W        5  // Holds 0..16

`endif

// ==== design/tile_pkg.sv ====
/*
 * Shared types of the backend slice
 *   group masks, instruction categories, register types
 *   register index and payload types, credit pool indices
 */
`default_nettype none

`include "tile_params.svh"

package tile_pkg;

  // One bit per slot of the rename group
  typedef logic [`TILE_DISP_SIZE-1:0] grp_id_t;

  typedef enum logic [2:0] {
    CAT_ALU,
    CAT_LSU,
    CAT_BRU,
    CAT_FPU,
    CAT_OTHER  // ROB credit only
  } inst_cat_e;

  typedef enum logic {
    GPR,
    FPR
  } reg_type_e;

  typedef logic [`TILE_RNID_W-1:0] rnid_t;
  typedef logic [`TILE_XLEN-1:0]   xlen_t;
  typedef logic [`TILE_FLEN-1:0]   flen_t;
  typedef logic [`TILE_CNT_W-1:0]  cnt_t;

  // ----------------------------------------------------------------------
  // Credit pools
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    POOL_ROB,
    POOL_ALU,
    POOL_LSU,
    POOL_BRU,
    POOL_FPU
  } pool_e;

  localparam int POOL_NUM = int'(POOL_FPU) + 1;

endpackage

`default_nettype wire

// ==== design/tile_credit_counter.sv ====
/*
 * Credit counter for one resource pool
 *   used count, updated by accepted need and returned credits
 *   fit check of the pending need against the pool size
 */
`default_nettype none

`include "tile_params.svh"

module tile_credit_counter #(
  parameter int POOL_SIZE = `TILE_ROB_SIZE
) (
  input  wire                 i_clk,
  input  wire                 i_rst_n,

  input  wire tile_pkg::cnt_t i_need,
  input  wire                 i_accept,
  input  wire tile_pkg::cnt_t i_ret_count,

  output logic                o_fits,
  output tile_pkg::cnt_t      o_used
);

  // One extra bit so used plus need cannot wrap
  localparam logic [`TILE_CNT_W:0] LIMIT = (`TILE_CNT_W+1)'(POOL_SIZE);

  tile_pkg::cnt_t          r_used;
  tile_pkg::cnt_t          w_add;
  logic [`TILE_CNT_W:0]    w_sum;

  assign w_sum  = {1'b0, r_used} + {1'b0, i_need};
  assign o_fits = (w_sum <= LIMIT);
  assign o_used = r_used;

  assign w_add = i_accept ? i_need : '0;  // Need counts only on accept

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      r_used <= '0;  // All credits free
    end else begin
      r_used <= r_used + w_add - i_ret_count;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Returning unit never gives back more than was taken
  a_ret_le_used : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_ret_count <= r_used
  ) else $error("credit return %0d exceeds used %0d", $sampled(i_ret_count), $sampled(r_used));

  a_used_le_size : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_accept |=> ({1'b0, r_used} <= LIMIT)
  ) else $error("used count %0d above pool size %0d", $sampled(r_used), POOL_SIZE);

endmodule

`default_nettype wire

// ==== design/tile_resource_alloc.sv ====
/*
 * Resource allocation for one rename group
 *   category decode into per-unit slot masks
 *   per-pool need counts and the five credit pools
 *   accept strobe and per-unit dispatch valids
 */
`default_nettype none

`include "tile_params.svh"

module tile_resource_alloc (
  input  wire                      i_clk,
  input  wire                      i_rst_n,

  input  wire                      i_grp_valid,
  input  wire tile_pkg::grp_id_t   i_inst_valid,
  input  wire tile_pkg::grp_id_t   i_inst_illegal,
  input  wire tile_pkg::inst_cat_e i_inst_cat [`TILE_DISP_SIZE],

  input  wire tile_pkg::cnt_t      i_ret_count [tile_pkg::POOL_NUM],

  output logic                     o_resource_ok,
  output tile_pkg::grp_id_t        o_disp_alu,
  output tile_pkg::grp_id_t        o_disp_lsu,
  output tile_pkg::grp_id_t        o_disp_bru,
  output tile_pkg::grp_id_t        o_disp_fpu
);

  tile_pkg::grp_id_t             w_live;
  tile_pkg::grp_id_t             w_alu_mask;
  tile_pkg::grp_id_t             w_lsu_mask;
  tile_pkg::grp_id_t             w_bru_mask;
  tile_pkg::grp_id_t             w_fpu_mask;
  tile_pkg::cnt_t                w_need [tile_pkg::POOL_NUM];
  logic [tile_pkg::POOL_NUM-1:0] w_fits;
  logic                          w_accept;

  function automatic tile_pkg::cnt_t count_ones(input tile_pkg::grp_id_t mask);
    tile_pkg::cnt_t cnt;
    cnt = '0;
    for (int i = 0; i < `TILE_DISP_SIZE; i++) begin
      cnt = cnt + tile_pkg::cnt_t'(mask[i]);
    end
    return cnt;
  endfunction

  // ----------------------------------------------------------------------
  // Category decode
  // ----------------------------------------------------------------------
  always_comb begin
    for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
      w_live[d]     = i_inst_valid[d] & ~i_inst_illegal[d];
      w_alu_mask[d] = w_live[d] & (i_inst_cat[d] == tile_pkg::CAT_ALU);
      w_lsu_mask[d] = w_live[d] & (i_inst_cat[d] == tile_pkg::CAT_LSU);
      w_bru_mask[d] = w_live[d] & (i_inst_cat[d] == tile_pkg::CAT_BRU);
      w_fpu_mask[d] = w_live[d] & (i_inst_cat[d] == tile_pkg::CAT_FPU);
    end
  end

  // Illegal slots still take a ROB entry
  assign w_need[tile_pkg::POOL_ROB] = count_ones(i_inst_valid);
  assign w_need[tile_pkg::POOL_ALU] = count_ones(w_alu_mask);
  assign w_need[tile_pkg::POOL_LSU] = count_ones(w_lsu_mask);
  assign w_need[tile_pkg::POOL_BRU] = count_ones(w_bru_mask);
  assign w_need[tile_pkg::POOL_FPU] = count_ones(w_fpu_mask);

  // ----------------------------------------------------------------------
  // Credit pools
  // ----------------------------------------------------------------------
  tile_credit_counter #(.POOL_SIZE(`TILE_ROB_SIZE)) u_rob_pool (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_need      (w_need[tile_pkg::POOL_ROB]),
    .i_accept    (w_accept),
    .i_ret_count (i_ret_count[tile_pkg::POOL_ROB]),
    .o_fits      (w_fits[tile_pkg::POOL_ROB]),
    .o_used      ()
  );

  tile_credit_counter #(.POOL_SIZE(`TILE_ALU_SIZE)) u_alu_pool (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_need      (w_need[tile_pkg::POOL_ALU]),
    .i_accept    (w_accept),
    .i_ret_count (i_ret_count[tile_pkg::POOL_ALU]),
    .o_fits      (w_fits[tile_pkg::POOL_ALU]),
    .o_used      ()
  );

  tile_credit_counter #(.POOL_SIZE(`TILE_LSU_SIZE)) u_lsu_pool (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_need      (w_need[tile_pkg::POOL_LSU]),
    .i_accept    (w_accept),
    .i_ret_count (i_ret_count[tile_pkg::POOL_LSU]),
    .o_fits      (w_fits[tile_pkg::POOL_LSU]),
    .o_used      ()
  );

  tile_credit_counter #(.POOL_SIZE(`TILE_BRU_SIZE)) u_bru_pool (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_need      (w_need[tile_pkg::POOL_BRU]),
    .i_accept    (w_accept),
    .i_ret_count (i_ret_count[tile_pkg::POOL_BRU]),
    .o_fits      (w_fits[tile_pkg::POOL_BRU]),
    .o_used      ()
  );

  tile_credit_counter #(.POOL_SIZE(`TILE_FPU_SIZE)) u_fpu_pool (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_need      (w_need[tile_pkg::POOL_FPU]),
    .i_accept    (w_accept),
    .i_ret_count (i_ret_count[tile_pkg::POOL_FPU]),
    .o_fits      (w_fits[tile_pkg::POOL_FPU]),
    .o_used      ()
  );

  assign o_resource_ok = &w_fits;  // Whole group or nothing
  assign w_accept      = i_grp_valid & o_resource_ok;

  assign o_disp_alu = {`TILE_DISP_SIZE{w_accept}} & w_alu_mask;
  assign o_disp_lsu = {`TILE_DISP_SIZE{w_accept}} & w_lsu_mask;
  assign o_disp_bru = {`TILE_DISP_SIZE{w_accept}} & w_bru_mask;
  assign o_disp_fpu = {`TILE_DISP_SIZE{w_accept}} & w_fpu_mask;

  // Each slot goes to at most one issue queue
  a_unit_onehot : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    ((o_disp_alu & o_disp_lsu) | (o_disp_alu & o_disp_bru) | (o_disp_alu & o_disp_fpu) |
     (o_disp_lsu & o_disp_bru) | (o_disp_lsu & o_disp_fpu) | (o_disp_bru & o_disp_fpu)) == '0
  ) else $error("slot dispatched to two units");

endmodule

`default_nettype wire

// ==== design/tile_phy_registers.sv ====
/*
 * Physical register file
 *   shared writeback ports filtered by destination register type
 *   payload width set by a type parameter, asynchronous read ports
 */
`default_nettype none

`include "tile_params.svh"

module tile_phy_registers #(
  parameter type                 data_t   = tile_pkg::xlen_t,
  parameter tile_pkg::reg_type_e REG_TYPE = tile_pkg::GPR,
  parameter int                  RD_PORTS = `TILE_INT_RD_PORTS
) (
  input  wire                      i_clk,
  input  wire                      i_rst_n,

  // Shared writeback ports
  input  wire                      i_wb_valid [`TILE_WB_PORTS],
  input  wire tile_pkg::reg_type_e i_wb_type  [`TILE_WB_PORTS],
  input  wire tile_pkg::rnid_t     i_wb_rnid  [`TILE_WB_PORTS],
  input  wire tile_pkg::xlen_t     i_wb_data  [`TILE_WB_PORTS],

  // Read ports
  input  wire tile_pkg::rnid_t     i_rd_rnid  [RD_PORTS],
  output data_t                    o_rd_data  [RD_PORTS]
);

  localparam int DATA_W = $bits(data_t);

  data_t                     r_regs [`TILE_PHY_REGS];
  logic [`TILE_WB_PORTS-1:0] w_wr_en;

  // Keep only writebacks aimed at this file
  always_comb begin
    for (int p = 0; p < `TILE_WB_PORTS; p++) begin
      w_wr_en[p] = i_wb_valid[p] & (i_wb_type[p] == REG_TYPE);
    end
  end

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `TILE_PHY_REGS; i++) begin
        r_regs[i] <= '0;
      end
    end else begin
      for (int p = 0; p < `TILE_WB_PORTS; p++) begin
        if (w_wr_en[p]) begin
          r_regs[i_wb_rnid[p]] <= i_wb_data[p][DATA_W-1:0];  // FP keeps low half
        end
      end
    end
  end

  // No bypass so a same-cycle write shows next cycle
  for (genvar r = 0; r < RD_PORTS; r++) begin : g_rd
    assign o_rd_data[r] = r_regs[i_rd_rnid[r]];
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < `TILE_WB_PORTS; p++) begin : g_wb_chk
    for (genvar q = p + 1; q < `TILE_WB_PORTS; q++) begin : g_pair
      // Rename hands out each rnid once, so two writers never collide
      a_no_dup_rnid : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(w_wr_en[p] && w_wr_en[q] && (i_wb_rnid[p] == i_wb_rnid[q]))
      ) else $error("writeback ports %0d and %0d hit rnid %0d", p, q,
                    $sampled(i_wb_rnid[p]));
    end
  end

endmodule

`default_nettype wire

// ==== design/tile_backend.sv ====
/*
 * Backend slice top
 *   resource allocation with dispatch valids
 *   integer and FP physical register files on shared writeback ports
 */
`default_nettype none

`include "tile_params.svh"

module tile_backend (
  input  wire                      i_clk,
  input  wire                      i_rst_n,

  // Rename group
  input  wire                      i_grp_valid,
  input  wire tile_pkg::grp_id_t   i_inst_valid,
  input  wire tile_pkg::grp_id_t   i_inst_illegal,
  input  wire tile_pkg::inst_cat_e i_inst_cat [`TILE_DISP_SIZE],

  // Credit returns
  input  wire tile_pkg::cnt_t      i_ret_count [tile_pkg::POOL_NUM],

  output logic                     o_resource_ok,
  output tile_pkg::grp_id_t        o_disp_alu,
  output tile_pkg::grp_id_t        o_disp_lsu,
  output tile_pkg::grp_id_t        o_disp_bru,
  output tile_pkg::grp_id_t        o_disp_fpu,

  // Writeback
  input  wire                      i_wb_valid [`TILE_WB_PORTS],
  input  wire tile_pkg::reg_type_e i_wb_type  [`TILE_WB_PORTS],
  input  wire tile_pkg::rnid_t     i_wb_rnid  [`TILE_WB_PORTS],
  input  wire tile_pkg::xlen_t     i_wb_data  [`TILE_WB_PORTS],

  // Register reads
  input  wire tile_pkg::rnid_t     i_int_rd_rnid [`TILE_INT_RD_PORTS],
  output tile_pkg::xlen_t          o_int_rd_data [`TILE_INT_RD_PORTS],
  input  wire tile_pkg::rnid_t     i_fp_rd_rnid  [`TILE_FP_RD_PORTS],
  output tile_pkg::flen_t          o_fp_rd_data  [`TILE_FP_RD_PORTS]
);

  // ----------------------------------------------------------------------
  // Allocation and dispatch
  // ----------------------------------------------------------------------
  tile_resource_alloc u_resource_alloc (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_grp_valid    (i_grp_valid),
    .i_inst_valid   (i_inst_valid),
    .i_inst_illegal (i_inst_illegal),
    .i_inst_cat     (i_inst_cat),
    .i_ret_count    (i_ret_count),
    .o_resource_ok  (o_resource_ok),
    .o_disp_alu     (o_disp_alu),
    .o_disp_lsu     (o_disp_lsu),
    .o_disp_bru     (o_disp_bru),
    .o_disp_fpu     (o_disp_fpu)
  );

  // ----------------------------------------------------------------------
  // Register files
  // ----------------------------------------------------------------------
  tile_phy_registers #(
    .data_t   (tile_pkg::xlen_t),
    .REG_TYPE (tile_pkg::GPR),
    .RD_PORTS (`TILE_INT_RD_PORTS)
  ) u_int_phy_registers (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wb_valid (i_wb_valid),
    .i_wb_type  (i_wb_type),
    .i_wb_rnid  (i_wb_rnid),
    .i_wb_data  (i_wb_data),
    .i_rd_rnid  (i_int_rd_rnid),
    .o_rd_data  (o_int_rd_data)
  );

  tile_phy_registers #(
    .data_t   (tile_pkg::flen_t),  // Low 32 bits of each writeback
    .REG_TYPE (tile_pkg::FPR),
    .RD_PORTS (`TILE_FP_RD_PORTS)
  ) u_fp_phy_registers (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wb_valid (i_wb_valid),
    .i_wb_type  (i_wb_type),
    .i_wb_rnid  (i_wb_rnid),
    .i_wb_data  (i_wb_data),
    .i_rd_rnid  (i_fp_rd_rnid),
    .o_rd_data  (o_fp_rd_data)
  );

endmodule

`default_nettype wire

// ==== verif/tb_tile_backend.sv ====
/*
 * Testbench for the backend slice
 *   clock, reset and LCG stimulus over five phases
 *   reference model of the credit pools and both register files
 *   concurrent assertions against the model, watchdog
 */
`default_nettype none

`include "tile_params.svh"

module tb_tile_backend;

  localparam int CLK_PERIOD  = 100;
  localparam int RESET_CYC   = 8;
  localparam int IDLE_CYC    = 16;
  localparam int DISP_CYC    = 200;
  localparam int EXH_CYC     = 24;
  localparam int DRAIN_CYC   = 4;
  localparam int RET_CYC     = 60;
  localparam int REG_CYC     = 120;
  localparam int END_CYC     = 2;
  localparam int MARGIN_CYC  = 50;
  localparam int TIMEOUT     = (RESET_CYC + IDLE_CYC + DISP_CYC + EXH_CYC + DRAIN_CYC +
                                RET_CYC + REG_CYC + END_CYC + MARGIN_CYC) * CLK_PERIOD;
  localparam int NPOOL       = tile_pkg::POOL_NUM;
  localparam int RNID_STRIDE = `TILE_PHY_REGS / `TILE_WB_PORTS;
  // Indexed by pool_e
  localparam int POOL_LIMIT [NPOOL] = '{`TILE_ROB_SIZE, `TILE_ALU_SIZE, `TILE_LSU_SIZE,
                                        `TILE_BRU_SIZE, `TILE_FPU_SIZE};

  logic                clk = 1'b0;
  logic                rst_n;
  logic                grp_valid;
  tile_pkg::grp_id_t   inst_valid;
  tile_pkg::grp_id_t   inst_illegal;
  tile_pkg::inst_cat_e inst_cat [`TILE_DISP_SIZE];
  tile_pkg::cnt_t      ret_count [NPOOL];
  logic                resource_ok;
  tile_pkg::grp_id_t   disp_alu;
  tile_pkg::grp_id_t   disp_lsu;
  tile_pkg::grp_id_t   disp_bru;
  tile_pkg::grp_id_t   disp_fpu;
  logic                wb_valid [`TILE_WB_PORTS];
  tile_pkg::reg_type_e wb_type  [`TILE_WB_PORTS];
  tile_pkg::rnid_t     wb_rnid  [`TILE_WB_PORTS];
  tile_pkg::xlen_t     wb_data  [`TILE_WB_PORTS];
  tile_pkg::rnid_t     int_rd_rnid [`TILE_INT_RD_PORTS];
  tile_pkg::xlen_t     int_rd_data [`TILE_INT_RD_PORTS];
  tile_pkg::rnid_t     fp_rd_rnid  [`TILE_FP_RD_PORTS];
  tile_pkg::flen_t     fp_rd_data  [`TILE_FP_RD_PORTS];

  // Reference model
  tile_pkg::cnt_t      m_used    [NPOOL];
  tile_pkg::cnt_t      used_next [NPOOL];
  tile_pkg::cnt_t      exp_need  [NPOOL];
  tile_pkg::grp_id_t   exp_mask  [NPOOL];
  tile_pkg::grp_id_t   exp_alu;
  tile_pkg::grp_id_t   exp_lsu;
  tile_pkg::grp_id_t   exp_bru;
  tile_pkg::grp_id_t   exp_fpu;
  tile_pkg::grp_id_t   disp_any;
  logic                exp_ok;
  logic                exp_accept;
  tile_pkg::xlen_t     m_int [`TILE_PHY_REGS];
  tile_pkg::flen_t     m_fp  [`TILE_PHY_REGS];
  tile_pkg::xlen_t     exp_int_rd [`TILE_INT_RD_PORTS];
  tile_pkg::flen_t     exp_fp_rd  [`TILE_FP_RD_PORTS];

  logic [31:0]         rng_state;
  tile_pkg::rnid_t     prev_rnid [`TILE_WB_PORTS];
  int                  rd_sweep;
  int                  err_cnt;
  string               test_name;
  logic                chk_idle;

  always #(CLK_PERIOD / 2) clk = ~clk;

  tile_backend u_tile_backend (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_grp_valid    (grp_valid),
    .i_inst_valid   (inst_valid),
    .i_inst_illegal (inst_illegal),
    .i_inst_cat     (inst_cat),
    .i_ret_count    (ret_count),
    .o_resource_ok  (resource_ok),
    .o_disp_alu     (disp_alu),
    .o_disp_lsu     (disp_lsu),
    .o_disp_bru     (disp_bru),
    .o_disp_fpu     (disp_fpu),
    .i_wb_valid     (wb_valid),
    .i_wb_type      (wb_type),
    .i_wb_rnid      (wb_rnid),
    .i_wb_data      (wb_data),
    .i_int_rd_rnid  (int_rd_rnid),
    .o_int_rd_data  (int_rd_data),
    .i_fp_rd_rnid   (fp_rd_rnid),
    .o_fp_rd_data   (fp_rd_data)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ (rng_state >> 16);  // Fold high bits down
  endfunction

  function automatic int cat_pool(input tile_pkg::inst_cat_e cat);
    case (cat)
      tile_pkg::CAT_ALU: return int'(tile_pkg::POOL_ALU);
      tile_pkg::CAT_LSU: return int'(tile_pkg::POOL_LSU);
      tile_pkg::CAT_BRU: return int'(tile_pkg::POOL_BRU);
      tile_pkg::CAT_FPU: return int'(tile_pkg::POOL_FPU);
      default:           return -1;  // ROB only
    endcase
  endfunction

  task automatic stop_run();
    err_cnt = err_cnt + 1;
    $display("Something failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
    stop_run();
  endtask

  // ----------------------------------------------------------------------
  // Model of pools, dispatch and register files
  // ----------------------------------------------------------------------
  always_comb begin
    int pi;
    exp_ok = 1'b1;
    for (int p = 0; p < NPOOL; p++) begin
      exp_need[p] = '0;
      exp_mask[p] = '0;
    end
    for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
      pi = cat_pool(inst_cat[d]);
      if (inst_valid[d]) begin
        exp_need[tile_pkg::POOL_ROB] = exp_need[tile_pkg::POOL_ROB] + tile_pkg::cnt_t'(1);
      end
      if (inst_valid[d] && !inst_illegal[d] && pi >= 0) begin
        exp_need[pi]    = exp_need[pi] + tile_pkg::cnt_t'(1);
        exp_mask[pi][d] = 1'b1;
      end
    end
    for (int p = 0; p < NPOOL; p++) begin
      if (int'(m_used[p]) + int'(exp_need[p]) > POOL_LIMIT[p]) begin
        exp_ok = 1'b0;
      end
    end
    exp_accept = grp_valid & exp_ok;
    for (int p = 0; p < NPOOL; p++) begin
      used_next[p] = tile_pkg::cnt_t'(int'(m_used[p]) + (exp_accept ? int'(exp_need[p]) : 0)
                                      - int'(ret_count[p]));
    end
    exp_alu = exp_accept ? exp_mask[tile_pkg::POOL_ALU] : '0;
    exp_lsu = exp_accept ? exp_mask[tile_pkg::POOL_LSU] : '0;
    exp_bru = exp_accept ? exp_mask[tile_pkg::POOL_BRU] : '0;
    exp_fpu = exp_accept ? exp_mask[tile_pkg::POOL_FPU] : '0;
    disp_any = disp_alu | disp_lsu | disp_bru | disp_fpu;
    for (int r = 0; r < `TILE_INT_RD_PORTS; r++) begin
      exp_int_rd[r] = m_int[int_rd_rnid[r]];
    end
    for (int r = 0; r < `TILE_FP_RD_PORTS; r++) begin
      exp_fp_rd[r] = m_fp[fp_rd_rnid[r]];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int p = 0; p < NPOOL; p++) begin
        m_used[p] <= '0;
      end
      for (int i = 0; i < `TILE_PHY_REGS; i++) begin
        m_int[i] <= '0;
        m_fp[i]  <= '0;
      end
    end else begin
      for (int p = 0; p < NPOOL; p++) begin
        m_used[p] <= used_next[p];
      end
      for (int p = 0; p < `TILE_WB_PORTS; p++) begin
        if (wb_valid[p] && wb_type[p] == tile_pkg::GPR) begin
          m_int[wb_rnid[p]] <= wb_data[p];
        end else if (wb_valid[p]) begin
          m_fp[wb_rnid[p]] <= wb_data[p][`TILE_FLEN-1:0];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  a_ok_match : assert property (@(posedge clk) disable iff (!rst_n) resource_ok == exp_ok)
    else mismatch("resource_ok", 64'($sampled(exp_ok)), 64'($sampled(resource_ok)));

  a_disp_alu : assert property (@(posedge clk) disable iff (!rst_n) disp_alu == exp_alu)
    else mismatch("alu valids", 64'($sampled(exp_alu)), 64'($sampled(disp_alu)));
  a_disp_lsu : assert property (@(posedge clk) disable iff (!rst_n) disp_lsu == exp_lsu)
    else mismatch("lsu valids", 64'($sampled(exp_lsu)), 64'($sampled(disp_lsu)));
  a_disp_bru : assert property (@(posedge clk) disable iff (!rst_n) disp_bru == exp_bru)
    else mismatch("bru valids", 64'($sampled(exp_bru)), 64'($sampled(disp_bru)));
  a_disp_fpu : assert property (@(posedge clk) disable iff (!rst_n) disp_fpu == exp_fpu)
    else mismatch("fpu valids", 64'($sampled(exp_fpu)), 64'($sampled(disp_fpu)));

  a_idle_no_disp : assert property (
    @(posedge clk) disable iff (!rst_n) !grp_valid |-> disp_any == '0
  ) else mismatch("valids with no group", 64'(0), 64'($sampled(disp_any)));

  a_blocked_no_disp : assert property (
    @(posedge clk) disable iff (!rst_n) !resource_ok |-> disp_any == '0
  ) else mismatch("valids while blocked", 64'(0), 64'($sampled(disp_any)));

  a_reset_idle : assert property (
    @(posedge clk) disable iff (!rst_n) chk_idle |-> (resource_ok && disp_any == '0)
  ) else begin
    $display("After reset the pools were not all free or a dispatch valid was raised");
    stop_run();
  end

  for (genvar r = 0; r < `TILE_INT_RD_PORTS; r++) begin : g_int_chk
    a_int_rd : assert property (@(posedge clk) disable iff (!rst_n)
      int_rd_data[r] == exp_int_rd[r]
    ) else mismatch("int read", $sampled(exp_int_rd[r]), $sampled(int_rd_data[r]));
  end

  for (genvar r = 0; r < `TILE_FP_RD_PORTS; r++) begin : g_fp_chk
    a_fp_rd : assert property (@(posedge clk) disable iff (!rst_n)
      fp_rd_data[r] == exp_fp_rd[r]
    ) else mismatch("fp read", 64'($sampled(exp_fp_rd[r])), 64'($sampled(fp_rd_data[r])));
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  task automatic drive_group(input int valid_pct);
    logic [31:0] rnd;
    rnd = lcg_next();
    grp_valid    <= int'(rnd % 100) < valid_pct;
    inst_valid   <= tile_pkg::grp_id_t'(rnd >> 8);
    inst_illegal <= tile_pkg::grp_id_t'(rnd >> 12) & tile_pkg::grp_id_t'(rnd >> 16);
    for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
      rnd = lcg_next();
      inst_cat[d] <= tile_pkg::inst_cat_e'(3'(rnd % 5));
    end
  endtask

  // Never more than the pool holds after this edge
  task automatic drive_returns(input bit enable);
    logic [31:0] rnd;
    for (int p = 0; p < NPOOL; p++) begin
      rnd = lcg_next();
      if (enable) begin
        ret_count[p] <= tile_pkg::cnt_t'(rnd % (32'(used_next[p]) + 1));
      end else begin
        ret_count[p] <= '0;
      end
    end
  endtask

  task automatic drive_regs(input bit enable);
    logic [31:0]     rnd;
    int              base;
    tile_pkg::rnid_t cur_rnid [`TILE_WB_PORTS];
    base = int'(lcg_next() % 32'(`TILE_PHY_REGS));
    for (int p = 0; p < `TILE_WB_PORTS; p++) begin
      rnd         = lcg_next();
      cur_rnid[p] = tile_pkg::rnid_t'(base + p * RNID_STRIDE);  // Distinct per cycle
      wb_valid[p] <= enable & rnd[31];
      wb_type[p]  <= tile_pkg::reg_type_e'(rnd[30]);
      wb_rnid[p]  <= cur_rnid[p];
      wb_data[p]  <= tile_pkg::xlen_t'({lcg_next(), rnd});
    end
    if (enable) begin
      int_rd_rnid[0] <= prev_rnid[0];  // Written last cycle
      int_rd_rnid[1] <= cur_rnid[2];   // Same-cycle write reads the old value
      fp_rd_rnid[0]  <= prev_rnid[1];
      fp_rd_rnid[1]  <= tile_pkg::rnid_t'(lcg_next());
    end else begin
      for (int r = 0; r < `TILE_INT_RD_PORTS; r++) begin
        int_rd_rnid[r] <= tile_pkg::rnid_t'(rd_sweep * `TILE_INT_RD_PORTS + r);
      end
      for (int r = 0; r < `TILE_FP_RD_PORTS; r++) begin
        fp_rd_rnid[r] <= tile_pkg::rnid_t'(rd_sweep * `TILE_FP_RD_PORTS + r);
      end
      rd_sweep = rd_sweep + 1;
    end
    for (int p = 0; p < `TILE_WB_PORTS; p++) begin
      prev_rnid[p] = cur_rnid[p];
    end
  endtask

  task automatic run_cycles(input int n, input int valid_pct, input bit ret_en,
                            input bit wb_en);
    repeat (n) begin
      @(posedge clk);
      drive_group(valid_pct);
      drive_returns(ret_en);
      drive_regs(wb_en);
    end
  endtask

  initial begin
    #(TIMEOUT);
    $display("Watchdog expired after %0d time units, the run did not finish", TIMEOUT);
    stop_run();
  end

  initial begin
    rng_state    = 32'd32;
    err_cnt      = 0;
    rd_sweep     = 0;
    test_name    = "reset";
    rst_n        <= 1'b0;
    chk_idle     <= 1'b0;
    grp_valid    <= 1'b0;
    inst_valid   <= '0;
    inst_illegal <= '0;
    for (int d = 0; d < `TILE_DISP_SIZE; d++) begin
      inst_cat[d] <= tile_pkg::CAT_OTHER;
    end
    for (int p = 0; p < NPOOL; p++) begin
      ret_count[p] <= '0;
    end
    for (int p = 0; p < `TILE_WB_PORTS; p++) begin
      wb_valid[p]  <= 1'b0;
      wb_type[p]   <= tile_pkg::GPR;
      wb_rnid[p]   <= '0;
      wb_data[p]   <= '0;
      prev_rnid[p] = '0;
    end
    for (int r = 0; r < `TILE_INT_RD_PORTS; r++) begin
      int_rd_rnid[r] <= '0;
    end
    for (int r = 0; r < `TILE_FP_RD_PORTS; r++) begin
      fp_rd_rnid[r] <= '0;
    end

    repeat (RESET_CYC) @(posedge clk);
    rst_n    <= 1'b1;
    chk_idle <= 1'b1;
    run_cycles(IDLE_CYC, 0, 1'b0, 1'b0);  // Also sweeps every register
    chk_idle <= 1'b0;

    test_name = "dispatch masks";
    run_cycles(DISP_CYC, 75, 1'b1, 1'b0);
    test_name = "credit exhaustion";
    run_cycles(EXH_CYC, 100, 1'b0, 1'b0);
    test_name = "credit return";
    run_cycles(DRAIN_CYC, 0, 1'b1, 1'b0);
    run_cycles(RET_CYC, 60, 1'b1, 1'b0);
    test_name = "register routing";
    run_cycles(REG_CYC, 0, 1'b0, 1'b1);
    run_cycles(END_CYC, 0, 1'b0, 1'b0);

    if (err_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/tile_pkg.sv
design/tile_credit_counter.sv
design/tile_resource_alloc.sv
design/tile_phy_registers.sv
design/tile_backend.sv
verif/tb_tile_backend.sv

// ==== Makefile ====
# Verilator build and run of the backend slice testbench
# Variables can be overridden on the command line, e.g. make sim JOBS=8

VERILATOR ?= verilator
TOP       ?= tb_tile_backend
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# The result is decided by the pass message in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
